// ==== board_datapath.sv ====
`timescale 1ns/1ps

module board_datapath import game_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  dp_cmd_t            cmd,
    input  tile_t              goal,
    input  board_t             load_board,
    input  logic [15:0]        rng_value,
    output board_t             board,
    output logic [SCORE_W-1:0] score,
    output dp_flags_t          flags
);

    // grid[r][c], r counts from the top row
    typedef row_t [3:0] grid_t;

    function automatic grid_t to_grid(board_t b);
        grid_t g;
        g[0] = b.row0;
        g[1] = b.row1;
        g[2] = b.row2;
        g[3] = b.row3;
        return g;
    endfunction

    function automatic board_t from_grid(grid_t g);
        board_t b;
        b.row0 = g[0];
        b.row1 = g[1];
        b.row2 = g[2];
        b.row3 = g[3];
        return b;
    endfunction

    grid_t              grid;
    grid_t              frame;
    grid_t              slid;
    grid_t              unframed;
    grid_t              spawn_grid;
    logic               dir_ok;
    logic [3:0]         row_changed;
    logic [SCORE_W-1:0] row_points [4];
    logic [SCORE_W-1:0] move_points;
    logic               move_changed;
    logic               board_win;
    logic               board_lose;

    assign grid = to_grid(board);

    // rotate into the left-move frame and back again
    always_comb begin
        dir_ok = 1'b1;
        frame = grid;
        unframed = grid;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                case (cmd.dir)
                    DIR_LEFT: begin
                        frame[i][j] = grid[i][j];
                        unframed[i][j] = slid[i][j];
                    end
                    DIR_RIGHT: begin
                        frame[i][j] = grid[i][3-j];
                        unframed[i][3-j] = slid[i][j];
                    end
                    DIR_UP: begin
                        frame[i][j] = grid[j][i];
                        unframed[j][i] = slid[i][j];
                    end
                    DIR_DOWN: begin
                        frame[i][j] = grid[3-j][i];
                        unframed[3-j][i] = slid[i][j];
                    end
                    default: dir_ok = 1'b0;
                endcase
            end
        end
    end

    for (genvar i = 0; i < 4; i++) begin : g_rows
        row_slide row_slide_i (
            .row_in  (frame[i]),
            .row_out (slid[i]),
            .points  (row_points[i]),
            .changed (row_changed[i])
        );
    end

    assign move_points = row_points[0] + row_points[1] + row_points[2] + row_points[3];
    assign move_changed = dir_ok && (row_changed != 4'b0000);

    // first row from the random start with a hole, lowest free column
    always_comb begin
        logic       found;
        logic [1:0] r;
        tile_t      exp_new;

        found = 1'b0;
        spawn_grid = grid;
        exp_new = (rng_value[7:4] == 4'h0) ? 4'd2 : 4'd1;
        for (int k = 0; k < 4; k++) begin
            r = rng_value[1:0] + 2'(k);
            for (int c = 0; c < 4; c++) begin
                if (!found && grid[r][c] == '0) begin
                    spawn_grid[r][c] = exp_new;
                    found = 1'b1;
                end
            end
        end
    end

    always_comb begin
        logic full;
        logic pair;

        board_win = 1'b0;
        full = 1'b1;
        pair = 1'b0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (grid[r][c] == goal) board_win = 1'b1;
                if (grid[r][c] == '0) full = 1'b0;
            end
        end
        // horizontal then vertical neighbours
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 3; c++) begin
                if (grid[r][c] == grid[r][c+1]) pair = 1'b1;
            end
        end
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (grid[r][c] == grid[r+1][c]) pair = 1'b1;
            end
        end
        board_lose = full && !pair;
    end

    assign flags = '{moved: move_changed, win: board_win, lose: board_lose};

    always_ff @(posedge clk) begin
        if (reset) begin
            board <= '0;
            score <= '0;
        end else begin
            case (cmd.op)
                OP_CLEAR: begin
                    board <= '0;
                    score <= '0;
                end
                OP_LOAD: begin
                    board <= load_board;
                    score <= '0;
                end
                OP_MOVE: begin
                    if (move_changed) begin
                        board <= from_grid(unframed);
                        score <= score + move_points;
                    end
                end
                OP_SPAWN: board <= from_grid(spawn_grid);
                default: begin
                    // hold
                end
            endcase
        end
    end

endmodule

// ==== dir_debounce.sv ====
`timescale 1ns/1ps

module dir_debounce import game_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  dir_t dir,
    input  logic waiting,
    output logic move_req,
    output dir_t move_dir
);

    logic [DEBOUNCE_W-1:0] idle_cnt;
    logic                  idle_full;
    logic                  accept;

    assign idle_full = (idle_cnt == DEBOUNCE_W'(DEBOUNCE_CYCLES));
    // two bits set never counts as a move
    assign accept = idle_full && waiting && $onehot(dir);

    always_ff @(posedge clk) begin
        if (reset) begin
            idle_cnt <= '0;
            move_req <= 1'b0;
        end else begin
            move_req <= accept;
            if (dir == DIR_NONE) begin
                // saturate once the idle time is met
                if (!idle_full) idle_cnt <= idle_cnt + 1'b1;
            end else begin
                idle_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) move_dir <= dir;
    end

endmodule

// ==== game_fsm.sv ====
`timescale 1ns/1ps

module game_fsm import game_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      load,
    input  logic      move_req,
    input  dir_t      move_dir,
    input  dp_flags_t flags,
    output dp_cmd_t   cmd,
    output logic      rng_step,
    output logic      waiting,
    output draw_st    status
);

    typedef enum logic [2:0] {
        S_CLEAR,
        S_SPAWN,
        S_CHECK,
        S_WAIT,
        S_MOVE,
        S_WIN,
        S_LOSE
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_CLEAR;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        cmd = '{op: OP_NOP, dir: DIR_NONE};
        rng_step = 1'b0;
        if (load) begin
            // restore wins over everything, even the end states
            cmd.op = OP_LOAD;
            next_state = S_CHECK;
        end else begin
            case (state)
                S_CLEAR: begin
                    cmd.op = OP_CLEAR;
                    next_state = S_SPAWN;
                end
                S_SPAWN: begin
                    cmd.op = OP_SPAWN;
                    rng_step = 1'b1;
                    next_state = S_CHECK;
                end
                S_CHECK: begin
                    if (flags.win) next_state = S_WIN;
                    else if (flags.lose) next_state = S_LOSE;
                    else next_state = S_WAIT;
                end
                S_WAIT: begin
                    if (move_req) next_state = S_MOVE;
                end
                S_MOVE: begin
                    cmd.op = OP_MOVE;
                    cmd.dir = move_dir;
                    // no spawn when the board stayed the same
                    next_state = flags.moved ? S_SPAWN : S_CHECK;
                end
                default: begin
                    // win and lose hold until reset or load
                end
            endcase
        end
    end

    assign waiting = (state == S_WAIT);

    always_comb begin
        case (state)
            S_WIN:   status = DRAW_WIN;
            S_LOSE:  status = DRAW_LOSE;
            default: status = DRAW_ACTIVE;
        endcase
    end

endmodule

// ==== game_pkg.sv ====
package game_pkg;

    // tile exponent, 0 means an empty cell
    typedef logic [3:0] tile_t;

    // index 0 is the cell a left move slides toward
    typedef tile_t [3:0] row_t;

    typedef struct packed {
        row_t row0;
        row_t row1;
        row_t row2;
        row_t row3;
    } board_t;

    // one-hot direction, anything else acts as none
    typedef enum logic [3:0] {
        DIR_NONE  = 4'b0000,
        DIR_LEFT  = 4'b0001,
        DIR_UP    = 4'b0010,
        DIR_DOWN  = 4'b0100,
        DIR_RIGHT = 4'b1000
    } dir_t;

    typedef enum logic [1:0] {
        DRAW_ACTIVE = 2'b00,
        DRAW_WIN    = 2'b01,
        DRAW_LOSE   = 2'b10
    } draw_st;

    typedef enum logic [2:0] {
        OP_NOP,
        OP_CLEAR,
        OP_LOAD,
        OP_MOVE,
        OP_SPAWN
    } dp_op_t;

    typedef struct packed {
        dp_op_t op;
        dir_t   dir;
    } dp_cmd_t;

    typedef struct packed {
        logic moved;
        logic win;
        logic lose;
    } dp_flags_t;

    localparam int    SCORE_W         = 16;
    localparam int    DEBOUNCE_CYCLES = 4;
    localparam int    DEBOUNCE_W      = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [15:0] RNG_SEED  = 16'hACE1;
    // a pair at this exponent stays apart
    localparam tile_t MAX_EXP         = 4'd15;

endpackage

// ==== game_top.sv ====
`timescale 1ns/1ps

module game_top import game_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  dir_t               dir,
    input  tile_t              goal,
    input  logic               load,
    input  board_t             load_board,
    output board_t             board,
    output logic [SCORE_W-1:0] score,
    output draw_st             status,
    output logic               ready
);

    logic        move_req;
    dir_t        move_dir;
    dp_cmd_t     dp_cmd;
    dp_flags_t   dp_flags;
    logic        rng_step;
    logic [15:0] rng_value;

    // ready is the wait level, it also gates the direction timer
    game_fsm game_fsm0 (
        .clk      (clk),
        .reset    (reset),
        .load     (load),
        .move_req (move_req),
        .move_dir (move_dir),
        .flags    (dp_flags),
        .cmd      (dp_cmd),
        .rng_step (rng_step),
        .waiting  (ready),
        .status   (status)
    );

    dir_debounce dir_debounce0 (
        .clk      (clk),
        .reset    (reset),
        .dir      (dir),
        .waiting  (ready),
        .move_req (move_req),
        .move_dir (move_dir)
    );

    spawn_rng spawn_rng0 (
        .clk   (clk),
        .reset (reset),
        .step  (rng_step),
        .value (rng_value)
    );

    board_datapath board_datapath0 (
        .clk        (clk),
        .reset      (reset),
        .cmd        (dp_cmd),
        .goal       (goal),
        .load_board (load_board),
        .rng_value  (rng_value),
        .board      (board),
        .score      (score),
        .flags      (dp_flags)
    );

endmodule

// ==== project.f ====
game_pkg.sv
row_slide.sv
spawn_rng.sv
dir_debounce.sv
board_datapath.sv
game_fsm.sv
game_top.sv
tb_game_props.sv
tb_game.sv

// ==== row_slide.sv ====
`timescale 1ns/1ps

module row_slide import game_pkg::*; (
    input  row_t               row_in,
    output row_t               row_out,
    output logic [SCORE_W-1:0] points,
    output logic               changed
);

    always_comb begin
        // compacted tiles plus a spare empty slot at the end
        tile_t comp [0:4];
        int    n;
        int    k;
        logic  skip;

        // pack the non-empty tiles toward index 0
        for (int i = 0; i < 5; i++) begin
            comp[i] = '0;
        end
        n = 0;
        for (int i = 0; i < 4; i++) begin
            if (row_in[i] != '0) begin
                comp[n] = row_in[i];
                n++;
            end
        end

        // merge equal neighbours, leftmost pair first
        row_out = '0;
        points = '0;
        k = 0;
        skip = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (skip) begin
                // partner of the pair just merged
                skip = 1'b0;
            end else if (comp[i] != '0) begin
                if (comp[i] == comp[i+1] && comp[i] < MAX_EXP) begin
                    row_out[k] = comp[i] + 4'd1;
                    points = points + (SCORE_W'(1) << (comp[i] + 4'd1));
                    skip = 1'b1;
                end else begin
                    row_out[k] = comp[i];
                end
                k++;
            end
        end
    end

    assign changed = (row_out != row_in);

endmodule

// ==== spawn_rng.sv ====
`timescale 1ns/1ps

module spawn_rng import game_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        step,
    output logic [15:0] value
);

    logic feedback;

    // taps 16, 14, 13, 11
    assign feedback = value[15] ^ value[13] ^ value[12] ^ value[10];

    always_ff @(posedge clk) begin
        if (reset) begin
            value <= RNG_SEED;
        end else if (step) begin
            // only moves on a spawn, so timing does not matter
            value <= {value[14:0], feedback};
        end
    end

endmodule

// ==== tb_game.sv ====
`timescale 1ns/1ps

module tb_game import game_pkg::*; ();

    localparam int NUM_CASES = 8;
    localparam int NUM_RANDOM = 12;
    localparam int WATCHDOG_CYCLES = (NUM_CASES + NUM_RANDOM) * 40 + 200;

    typedef struct packed {
        board_t             start;
        tile_t              goal;
        dir_t               dir;
        logic               taken;
        board_t             moved;
        logic [SCORE_W-1:0] score;
        draw_st             status;
    } move_case_t;

    logic               clk;
    logic               reset;
    dir_t               dir;
    tile_t              goal;
    logic               load;
    board_t             load_board;
    board_t             board;
    logic [SCORE_W-1:0] score;
    draw_st             status;
    logic               ready;

    move_case_t  cases [NUM_CASES];
    logic [15:0] m_lfsr;
    integer      seed;
    int          errs;
    int          tests_ok;
    int          tests_bad;

    game_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .dir        (dir),
        .goal       (goal),
        .load       (load),
        .load_board (load_board),
        .board      (board),
        .score      (score),
        .status     (status),
        .ready      (ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic tile_t cell_at(board_t b, int r, int c);
        logic [63:0] v;
        v = b;
        return v[(3 - r) * 16 + 4 * c +: 4];
    endfunction

    function automatic board_t put_cell(board_t b, int r, int c, tile_t t);
        logic [63:0] v;
        v = b;
        v[(3 - r) * 16 + 4 * c +: 4] = t;
        return board_t'(v);
    endfunction

    // hex digits row by row with the leftmost column first
    function automatic board_t from_rows(logic [63:0] v);
        board_t b;
        b = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                b = put_cell(b, r, c, v[63 - 16 * r - 4 * c -: 4]);
            end
        end
        return b;
    endfunction

    // board cell r*4+c seen at line i, position j of a left move
    function automatic int frame_cell(dir_t d, int i, int j);
        case (d)
            DIR_RIGHT: return i * 4 + 3 - j;
            DIR_UP:    return j * 4 + i;
            DIR_DOWN:  return (3 - j) * 4 + i;
            default:   return i * 4 + j;
        endcase
    endfunction

    function automatic logic [15:0] lfsr_next(logic [15:0] v);
        return {v[14:0], v[15] ^ v[13] ^ v[12] ^ v[10]};
    endfunction

    function automatic move_case_t make_case(logic [63:0] start_rows, tile_t goal_exp,
            dir_t d, logic taken, logic [63:0] moved_rows, int pts, draw_st st);
        move_case_t tc;
        tc.start = from_rows(start_rows);
        tc.goal = goal_exp;
        tc.dir = d;
        tc.taken = taken;
        tc.moved = from_rows(moved_rows);
        tc.score = SCORE_W'(pts);
        tc.status = st;
        return tc;
    endfunction

    task automatic slide_board(input board_t b, input dir_t d, output board_t nb,
            output int pts);
        tile_t line [4];
        tile_t res [4];
        logic  fused [4];
        int    k;
        int    pos;
        nb = b;
        pts = 0;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                pos = frame_cell(d, i, j);
                line[j] = cell_at(b, pos / 4, pos % 4);
                res[j] = '0;
                fused[j] = 1'b0;
            end
            k = 0;
            for (int j = 0; j < 4; j++) begin
                if (line[j] != '0) begin
                    if (k > 0 && res[k-1] == line[j] && !fused[k-1] && line[j] < MAX_EXP) begin
                        res[k-1] = line[j] + 4'd1;
                        fused[k-1] = 1'b1;
                        pts += 1 << (line[j] + 4'd1);
                    end else begin
                        res[k] = line[j];
                        k++;
                    end
                end
            end
            for (int j = 0; j < 4; j++) begin
                pos = frame_cell(d, i, j);
                nb = put_cell(nb, pos / 4, pos % 4, res[j]);
            end
        end
    endtask

    task automatic place_spawn(inout board_t b, input logic [15:0] rng);
        tile_t e;
        int    r;
        logic  done;
        e = (rng[7:4] == 4'h0) ? 4'd2 : 4'd1;
        done = 1'b0;
        for (int k = 0; k < 4; k++) begin
            r = (rng[1:0] + k) % 4;
            for (int c = 0; c < 4; c++) begin
                if (!done && cell_at(b, r, c) == '0) begin
                    b = put_cell(b, r, c, e);
                    done = 1'b1;
                end
            end
        end
    endtask

    // cycles until ready or an end state
    task automatic wait_settle(output int n);
        logic done;
        n = 0;
        done = 1'b0;
        while (!done && n < 20) begin
            @(posedge clk);
            #1;
            n++;
            done = ready || (status != DRAW_ACTIVE);
        end
        if (!done) begin
            $display("ERROR: DUT did not return to the wait state");
            errs++;
        end
    endtask

    task automatic load_game(input board_t b, input tile_t g, output int settle);
        load = 1'b1;
        load_board = b;
        goal = g;
        @(posedge clk);
        #1;
        load = 1'b0;
        wait_settle(settle);
    endtask

    task automatic apply_dir(input dir_t d, output logic taken, output int settle);
        logic   was_ready;
        draw_st was_status;
        int     n;
        taken = 1'b0;
        settle = 0;
        n = 0;
        // let the idle counter fill first
        repeat (DEBOUNCE_CYCLES) @(posedge clk);
        #1;
        was_ready = ready;
        was_status = status;
        dir = d;
        while (!taken && n < DEBOUNCE_CYCLES + 4) begin
            @(posedge clk);
            #1;
            n++;
            // a move shows as ready falling or as an end state being left
            if ((was_ready && !ready) || status != was_status) taken = 1'b1;
        end
        dir = DIR_NONE;
        if (taken) wait_settle(settle);
    endtask

    task automatic compare_state(input board_t eb, input logic [SCORE_W-1:0] es,
            input draw_st est);
        if (board !== eb) begin
            $display("FAILED board: got %h expected %h", board, eb);
            errs++;
        end
        if (score !== es) begin
            $display("FAILED score: got %h expected %h", score, es);
            errs++;
        end
        if (status !== est) begin
            $display("FAILED status: got %h expected %h", status, est);
            errs++;
        end
    endtask

    task automatic end_test(input string name, input int errs0);
        if (errs == errs0) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic run_case(input string name, input move_case_t tc);
        int     errs0;
        int     settle;
        logic   taken;
        logic   taken2;
        board_t exp_b;
        errs0 = errs;
        load_game(tc.start, tc.goal, settle);
        apply_dir(tc.dir, taken, settle);
        if (taken !== tc.taken) begin
            $display("ERROR: direction %h acceptance was %0b, expected %0b", tc.dir, taken,
                tc.taken);
            errs++;
        end
        exp_b = tc.moved;
        if (tc.taken && tc.moved != tc.start) begin
            place_spawn(exp_b, m_lfsr);
            m_lfsr = lfsr_next(m_lfsr);
        end
        if (taken && settle != ((tc.moved != tc.start) ? 3 : 2)) begin
            $display("ERROR: ready returned %0d cycles after the move started", settle);
            errs++;
        end
        compare_state(exp_b, tc.score, tc.status);
        // a finished game ignores further directions
        if (tc.status != DRAW_ACTIVE) begin
            apply_dir(DIR_RIGHT, taken2, settle);
            if (taken2) begin
                $display("ERROR: a direction was accepted after the game ended");
                errs++;
            end
            compare_state(exp_b, tc.score, tc.status);
        end
        end_test(name, errs0);
    endtask

    task automatic held_direction();
        board_t start;
        board_t exp_b;
        int     pts;
        int     total;
        int     n;
        int     settle;
        int     drops;
        logic   taken;
        int     errs0;
        errs0 = errs;
        start = from_rows(64'h1100_0000_0000_0000);
        load_game(start, 4'd11, settle);
        repeat (DEBOUNCE_CYCLES) @(posedge clk);
        #1;
        dir = DIR_LEFT;
        n = 0;
        while (ready && n < DEBOUNCE_CYCLES + 4) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (ready) begin
            $display("ERROR: held direction was never accepted");
            errs++;
        end
        wait_settle(settle);
        drops = 0;
        repeat (2 * DEBOUNCE_CYCLES + 4) begin
            @(posedge clk);
            #1;
            if (!ready) drops++;
        end
        dir = DIR_NONE;
        if (drops != 0) begin
            $display("ERROR: held direction was accepted more than once");
            errs++;
        end
        slide_board(start, DIR_LEFT, exp_b, pts);
        place_spawn(exp_b, m_lfsr);
        m_lfsr = lfsr_next(m_lfsr);
        total = pts;
        compare_state(exp_b, SCORE_W'(total), DRAW_ACTIVE);
        // release one cycle too short and then hold
        repeat (DEBOUNCE_CYCLES - 1) @(posedge clk);
        #1;
        dir = DIR_UP;
        drops = 0;
        repeat (DEBOUNCE_CYCLES + 4) begin
            @(posedge clk);
            #1;
            if (!ready) drops++;
        end
        dir = DIR_NONE;
        if (drops != 0) begin
            $display("ERROR: direction accepted before the idle time was met");
            errs++;
        end
        apply_dir(DIR_UP, taken, settle);
        if (!taken) begin
            $display("ERROR: direction not accepted after a full idle time");
            errs++;
        end
        start = exp_b;
        slide_board(start, DIR_UP, exp_b, pts);
        if (exp_b != start) begin
            place_spawn(exp_b, m_lfsr);
            m_lfsr = lfsr_next(m_lfsr);
        end
        total += pts;
        compare_state(exp_b, SCORE_W'(total), DRAW_ACTIVE);
        end_test("held direction", errs0);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog timeout, the run did not finish");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        board_t     exp_b;
        board_t     rb;
        board_t     mb;
        dir_t       rd;
        int         pts;
        int         n;
        int         errs0;
        move_case_t tc;

        reset = 1'b1;
        dir = DIR_NONE;
        goal = 4'd11;
        load = 1'b0;
        load_board = '0;
        seed = 32'hc30b_c403;
        errs = 0;
        tests_ok = 0;
        tests_bad = 0;

        cases[0] = make_case(64'h1122_2022_0000_ff01, 4'd11, DIR_LEFT, 1'b1,
            64'h2300_3200_0000_ff10, 20, DRAW_ACTIVE);
        cases[1] = make_case(64'h1110_0003_2222_0404, 4'd11, DIR_RIGHT, 1'b1,
            64'h0012_0003_0033_0005, 52, DRAW_ACTIVE);
        cases[2] = make_case(64'h1020_1020_0320_1320, 4'd11, DIR_UP, 1'b1,
            64'h2430_1030_0000_0000, 36, DRAW_ACTIVE);
        cases[3] = make_case(64'h0501_0500_2001_2500, 4'd11, DIR_DOWN, 1'b1,
            64'h0000_0000_0500_3602, 76, DRAW_ACTIVE);
        // nothing slides and nothing spawns
        cases[4] = make_case(64'h1200_3000_0000_ff00, 4'd11, DIR_LEFT, 1'b1,
            64'h1200_3000_0000_ff00, 0, DRAW_ACTIVE);
        cases[5] = make_case(64'h4400_1000_0000_0000, 4'd5, DIR_LEFT, 1'b1,
            64'h5000_1000_0000_0000, 32, DRAW_WIN);
        cases[6] = make_case(64'h1212_2121_1212_2121, 4'd11, DIR_LEFT, 1'b0,
            64'h1212_2121_1212_2121, 0, DRAW_LOSE);
        cases[7] = make_case(64'h0100_0000_0000_0000, 4'd11, dir_t'(4'b0011), 1'b0,
            64'h0100_0000_0000_0000, 0, DRAW_ACTIVE);

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        errs0 = errs;
        n = 0;
        while (!ready && n < 10) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (n != 3) begin
            $display("ERROR: ready rose %0d cycles after reset, expected 3", n);
            errs++;
        end
        exp_b = '0;
        m_lfsr = RNG_SEED;
        place_spawn(exp_b, m_lfsr);
        m_lfsr = lfsr_next(m_lfsr);
        compare_state(exp_b, '0, DRAW_ACTIVE);
        end_test("reset", errs0);

        for (int i = 0; i < NUM_CASES; i++) begin
            run_case($sformatf("table %0d", i), cases[i]);
        end

        // two forced holes keep these games active
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rb = '0;
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    rb = put_cell(rb, r, c, tile_t'($random(seed) & 3));
                end
            end
            rb = put_cell(rb, 1, 2, 4'd0);
            rb = put_cell(rb, 2, 1, 4'd0);
            rd = dir_t'(4'b0001 << ($random(seed) & 3));
            slide_board(rb, rd, mb, pts);
            tc = '{start: rb, goal: 4'd11, dir: rd, taken: 1'b1, moved: mb,
                score: SCORE_W'(pts), status: DRAW_ACTIVE};
            run_case($sformatf("random %0d", i), tc);
        end

        held_direction();

        $display("tests: %0d passed, %0d failed", tests_ok, tests_bad);
        if (errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tb_game_props.sv ====
`timescale 1ns/1ps

module game_props import game_pkg::*; (
    input logic               clk,
    input logic               reset,
    input logic               load,
    input logic               ready,
    input draw_st             status,
    input logic [SCORE_W-1:0] score
);

    // win and lose hold until a board is loaded
    end_state_held: assert property (@(posedge clk) disable iff (reset)
        (status != DRAW_ACTIVE && !load) |=> $stable(status))
        else $error("end state left without reset or load");

    no_ready_when_over: assert property (@(posedge clk) disable iff (reset)
        (status != DRAW_ACTIVE) |-> !ready)
        else $error("ready high outside the active state");

    // only a load may bring the score back down
    score_grows: assert property (@(posedge clk) disable iff (reset)
        !load |=> (score >= $past(score)))
        else $error("score decreased without reset or load");

endmodule

bind game_top game_props props0 (
    .clk    (clk),
    .reset  (reset),
    .load   (load),
    .ready  (ready),
    .status (status),
    .score  (score)
);
